//--- hdl/leaf_cfg.svh
`ifndef LEAF_CFG_SVH
`define LEAF_CFG_SVH

// network packet and payload widths.
`define LEAF_PACKET_BITS  49
`define LEAF_PAYLOAD_BITS 32

// header field widths.
`define LEAF_LEAF_BITS    5
`define LEAF_PORT_BITS    4
`define LEAF_TAG_BITS     7

// field positions, payload sits at the bottom.
`define LEAF_TAG_LSB      (`LEAF_PAYLOAD_BITS)
`define LEAF_PORT_LSB     (`LEAF_TAG_LSB + `LEAF_TAG_BITS)
`define LEAF_LEAF_LSB     (`LEAF_PORT_LSB + `LEAF_PORT_BITS)
`define LEAF_VALID_BIT    (`LEAF_LEAF_LSB + `LEAF_LEAF_BITS)

// addressing.
`define LEAF_OWN_ADDR     5'd3
`define LEAF_DEST_LEAF    5'd9
`define LEAF_DEST_PORT    4'd2

// per-port buffering, power of two.
`define LEAF_FIFO_DEPTH   8

`endif

//--- hdl/leaf_pkg.sv
`include "leaf_cfg.svh"

package leaf_pkg;

    // full network word.
    typedef logic [`LEAF_PACKET_BITS-1:0] packet_t;

    // user data word.
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] payload_t;

    // header fields.
    typedef logic [`LEAF_LEAF_BITS-1:0] leaf_addr_t;
    typedef logic [`LEAF_PORT_BITS-1:0] port_id_t;
    typedef logic [`LEAF_TAG_BITS-1:0] tag_t;

    // kernel control.
    typedef enum logic [1:0] {
        IDLE,   // waiting for ap_start.
        GATHER, // waiting for all four inputs.
        OFFER   // sum held for the packer.
    } kernel_state_t;

endpackage

//--- hdl/port_fifo.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module port_fifo #(
    parameter int depth = `LEAF_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  leaf_pkg::payload_t wr_data,
    output logic               full,
    output logic               vld,
    output leaf_pkg::payload_t data,
    input  logic               ack
);

    localparam int ptr_bits = $clog2(depth);

    leaf_pkg::payload_t  mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;
    logic                do_rd;

    if ((depth < 2) || ((depth & (depth - 1)) != 0)) begin : g_depth_check
        $error("port_fifo depth must be a power of two");
    end

    assign do_rd = ack && vld;
    assign vld   = (count != '0);
    assign full  = (count == (ptr_bits + 1)'(depth));
    assign data  = mem[rd_ptr]; // head word, shown while vld.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // writer must drop words itself once the buffer is full.
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> !wr_en
    );

    ack_needs_vld: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> vld
    );

endmodule

//--- hdl/leaf_rx_demux.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_rx_demux (
    input  logic               clk,
    input  logic               rst_n,
    input  leaf_pkg::packet_t  din_leaf_bft2interface,
    output leaf_pkg::payload_t dout_leaf_interface2user_1,
    output leaf_pkg::payload_t dout_leaf_interface2user_2,
    output leaf_pkg::payload_t dout_leaf_interface2user_3,
    output leaf_pkg::payload_t dout_leaf_interface2user_4,
    output logic               vld_interface2user_1,
    output logic               vld_interface2user_2,
    output logic               vld_interface2user_3,
    output logic               vld_interface2user_4,
    input  logic               ack_user2interface_1,
    input  logic               ack_user2interface_2,
    input  logic               ack_user2interface_3,
    input  logic               ack_user2interface_4
);

    logic                 pkt_valid;
    leaf_pkg::leaf_addr_t pkt_leaf;
    leaf_pkg::port_id_t   pkt_port;
    leaf_pkg::payload_t   pkt_payload;
    logic                 for_me;

    logic [3:0]           wr_en;
    logic [3:0]           full;
    logic [3:0]           fifo_vld;
    logic [3:0]           fifo_ack;
    leaf_pkg::payload_t   fifo_data [4];

    // field decode.
    assign pkt_valid   = din_leaf_bft2interface[`LEAF_VALID_BIT];
    assign pkt_leaf    = din_leaf_bft2interface[`LEAF_LEAF_LSB +: `LEAF_LEAF_BITS];
    assign pkt_port    = din_leaf_bft2interface[`LEAF_PORT_LSB +: `LEAF_PORT_BITS];
    assign pkt_payload = din_leaf_bft2interface[`LEAF_PAYLOAD_BITS-1:0];

    assign for_me = pkt_valid && (pkt_leaf == `LEAF_OWN_ADDR);

    assign fifo_ack = {ack_user2interface_4, ack_user2interface_3,
                       ack_user2interface_2, ack_user2interface_1};

    assign vld_interface2user_1 = fifo_vld[0];
    assign vld_interface2user_2 = fifo_vld[1];
    assign vld_interface2user_3 = fifo_vld[2];
    assign vld_interface2user_4 = fifo_vld[3];

    assign dout_leaf_interface2user_1 = fifo_data[0];
    assign dout_leaf_interface2user_2 = fifo_data[1];
    assign dout_leaf_interface2user_3 = fifo_data[2];
    assign dout_leaf_interface2user_4 = fifo_data[3];

    for (genvar i = 0; i < 4; i++) begin : g_port
        // network port i+1 feeds fifo i, a full fifo drops the word.
        assign wr_en[i] = for_me
                          && (pkt_port == leaf_pkg::port_id_t'(i + 1))
                          && !full[i];

        port_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (pkt_payload),
            .full    (full[i]),
            .vld     (fifo_vld[i]),
            .data    (fifo_data[i]),
            .ack     (fifo_ack[i])
        );
    end

    // a written word is visible to the kernel one cycle later.
    write_shows_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en != '0) |=> ((fifo_vld & $past(wr_en)) == $past(wr_en))
    );

endmodule

//--- hdl/user_kernel.sv
`timescale 1ns/1ps

module user_kernel (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ap_start,
    input  leaf_pkg::payload_t dout_leaf_interface2user_1,
    input  leaf_pkg::payload_t dout_leaf_interface2user_2,
    input  leaf_pkg::payload_t dout_leaf_interface2user_3,
    input  leaf_pkg::payload_t dout_leaf_interface2user_4,
    input  logic               vld_interface2user_1,
    input  logic               vld_interface2user_2,
    input  logic               vld_interface2user_3,
    input  logic               vld_interface2user_4,
    output logic               ack_user2interface_1,
    output logic               ack_user2interface_2,
    output logic               ack_user2interface_3,
    output logic               ack_user2interface_4,
    output leaf_pkg::payload_t din_leaf_user2interface_1,
    output logic               vld_user2interface_1,
    input  logic               ack_interface2user_1
);

    leaf_pkg::kernel_state_t state;
    leaf_pkg::payload_t      sum_q;
    logic                    all_vld;
    logic                    take;

    assign all_vld = vld_interface2user_1 && vld_interface2user_2
                     && vld_interface2user_3 && vld_interface2user_4;
    assign take    = (state == leaf_pkg::GATHER) && all_vld;

    // all four ports are popped together.
    assign ack_user2interface_1 = take;
    assign ack_user2interface_2 = take;
    assign ack_user2interface_3 = take;
    assign ack_user2interface_4 = take;

    assign vld_user2interface_1      = (state == leaf_pkg::OFFER);
    assign din_leaf_user2interface_1 = sum_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= leaf_pkg::IDLE;
        end else begin
            case (state)
                leaf_pkg::IDLE: begin
                    if (ap_start) state <= leaf_pkg::GATHER;
                end
                leaf_pkg::GATHER: begin
                    if (take) state <= leaf_pkg::OFFER;
                end
                leaf_pkg::OFFER: begin
                    if (ack_interface2user_1) state <= leaf_pkg::GATHER;
                end
                default: state <= leaf_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sum_q <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2
                     + dout_leaf_interface2user_3 + dout_leaf_interface2user_4; // mod 2^32.
        end
    end

    acks_rise_together: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack_user2interface_1) |-> ($rose(ack_user2interface_2)
            && $rose(ack_user2interface_3) && $rose(ack_user2interface_4))
    );

endmodule

//--- hdl/leaf_tx_packer.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module leaf_tx_packer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               resend,
    input  leaf_pkg::payload_t din_leaf_user2interface_1,
    input  logic               vld_user2interface_1,
    output logic               ack_interface2user_1,
    output leaf_pkg::packet_t  dout_leaf_interface2bft
);

    leaf_pkg::tag_t tag_q;

    // resend holds the kernel off.
    assign ack_interface2user_1 = vld_user2interface_1 && !resend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_leaf_interface2bft <= '0;
            tag_q                   <= '0;
        end else if (ack_interface2user_1) begin
            dout_leaf_interface2bft <= {1'b1,
                                        `LEAF_DEST_LEAF,
                                        `LEAF_DEST_PORT,
                                        tag_q,
                                        din_leaf_user2interface_1};
            tag_q                   <= tag_q + leaf_pkg::tag_t'(1); // wraps at 128.
        end else begin
            dout_leaf_interface2bft <= '0; // idle word.
        end
    end

    resend_blanks_output: assert property (
        @(posedge clk) disable iff (!rst_n) resend |=> (dout_leaf_interface2bft == '0)
    );

endmodule

//--- hdl/leaf_i4o1.sv
`timescale 1ns/1ps

module leaf_i4o1 (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  logic              resend,
    input  logic              ap_start
);

    leaf_pkg::payload_t dout_leaf_interface2user_1;
    leaf_pkg::payload_t dout_leaf_interface2user_2;
    leaf_pkg::payload_t dout_leaf_interface2user_3;
    leaf_pkg::payload_t dout_leaf_interface2user_4;
    logic               vld_interface2user_1;
    logic               vld_interface2user_2;
    logic               vld_interface2user_3;
    logic               vld_interface2user_4;
    logic               ack_user2interface_1;
    logic               ack_user2interface_2;
    logic               ack_user2interface_3;
    logic               ack_user2interface_4;

    leaf_pkg::payload_t din_leaf_user2interface_1;
    logic               vld_user2interface_1;
    logic               ack_interface2user_1;

    leaf_rx_demux u_rx_demux (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .din_leaf_bft2interface     (din_leaf_bft2interface),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2 (dout_leaf_interface2user_2),
        .dout_leaf_interface2user_3 (dout_leaf_interface2user_3),
        .dout_leaf_interface2user_4 (dout_leaf_interface2user_4),
        .vld_interface2user_1       (vld_interface2user_1),
        .vld_interface2user_2       (vld_interface2user_2),
        .vld_interface2user_3       (vld_interface2user_3),
        .vld_interface2user_4       (vld_interface2user_4),
        .ack_user2interface_1       (ack_user2interface_1),
        .ack_user2interface_2       (ack_user2interface_2),
        .ack_user2interface_3       (ack_user2interface_3),
        .ack_user2interface_4       (ack_user2interface_4)
    );

    user_kernel u_user_kernel (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .ap_start                   (ap_start),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2 (dout_leaf_interface2user_2),
        .dout_leaf_interface2user_3 (dout_leaf_interface2user_3),
        .dout_leaf_interface2user_4 (dout_leaf_interface2user_4),
        .vld_interface2user_1       (vld_interface2user_1),
        .vld_interface2user_2       (vld_interface2user_2),
        .vld_interface2user_3       (vld_interface2user_3),
        .vld_interface2user_4       (vld_interface2user_4),
        .ack_user2interface_1       (ack_user2interface_1),
        .ack_user2interface_2       (ack_user2interface_2),
        .ack_user2interface_3       (ack_user2interface_3),
        .ack_user2interface_4       (ack_user2interface_4),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .vld_user2interface_1       (vld_user2interface_1),
        .ack_interface2user_1       (ack_interface2user_1)
    );

    leaf_tx_packer u_tx_packer (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .resend                    (resend),
        .din_leaf_user2interface_1 (din_leaf_user2interface_1),
        .vld_user2interface_1      (vld_user2interface_1),
        .ack_interface2user_1      (ack_interface2user_1),
        .dout_leaf_interface2bft   (dout_leaf_interface2bft)
    );

endmodule

//--- testbench/tb_leaf_i4o1.sv
`timescale 1ns/1ps
`include "leaf_cfg.svh"

module tb_leaf_i4o1;

    logic              clk;
    logic              rst_n;
    leaf_pkg::packet_t din_leaf_bft2interface;
    leaf_pkg::packet_t dout_leaf_interface2bft;
    logic              resend;
    logic              ap_start;

    // reference model.
    leaf_pkg::payload_t port_q [4][$]; // accepted words per port.
    leaf_pkg::packet_t  exp_q [$];     // expected output packets.
    leaf_pkg::packet_t  exp_head;
    logic               exp_valid;
    leaf_pkg::tag_t     exp_tag;
    logic               started;

    string test_name;
    int    errors;
    int    tests;
    int    received;
    int    sets_made;
    int    err_mark;
    int    rcv_mark;
    int    set_mark;
    int    port_order [4];

    leaf_i4o1 dut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic void refresh_head();
        exp_valid = (exp_q.size() != 0);
        exp_head  = '0;
        if (exp_valid) begin
            exp_head = exp_q[0];
        end
    endfunction

    function automatic leaf_pkg::packet_t make_packet(input logic valid,
                                                      input leaf_pkg::leaf_addr_t leaf,
                                                      input leaf_pkg::port_id_t port,
                                                      input leaf_pkg::payload_t payload);
        leaf_pkg::tag_t tag;
        tag = leaf_pkg::tag_t'($urandom); // input tag is don't care.
        return {valid, leaf, port, tag, payload};
    endfunction

    // applies the leaf's accept rules and forms sums once every port has a word.
    task automatic record_packet(input leaf_pkg::packet_t pkt);
        leaf_pkg::leaf_addr_t leaf;
        leaf_pkg::port_id_t   port;
        leaf_pkg::payload_t   sum;
        leaf = pkt[47:43];
        port = pkt[42:39];
        if (pkt[48] && (leaf == `LEAF_OWN_ADDR) && (port >= 4'd1) && (port <= 4'd4)) begin
            port_q[int'(port) - 1].push_back(pkt[31:0]);
        end
        if ((port_q[0].size() != 0) && (port_q[1].size() != 0)
                && (port_q[2].size() != 0) && (port_q[3].size() != 0)) begin
            sum = port_q[0].pop_front() + port_q[1].pop_front()
                  + port_q[2].pop_front() + port_q[3].pop_front();
            exp_q.push_back({1'b1, `LEAF_DEST_LEAF, `LEAF_DEST_PORT, exp_tag, sum});
            exp_tag++;
            sets_made++;
            refresh_head();
        end
    endtask

    // one packet per cycle, driven 1 ns after the edge.
    task automatic send_packet(input leaf_pkg::packet_t pkt);
        din_leaf_bft2interface = pkt;
        record_packet(pkt);
        @(posedge clk);
        #1;
        din_leaf_bft2interface = '0;
    endtask

    task automatic send_word(input int port, input leaf_pkg::payload_t payload);
        send_packet(make_packet(1'b1, `LEAF_OWN_ADDR, leaf_pkg::port_id_t'(port), payload));
    endtask

    task automatic send_junk(input int kind);
        leaf_pkg::leaf_addr_t leaf;
        leaf_pkg::port_id_t   port;
        leaf = `LEAF_OWN_ADDR;
        port = leaf_pkg::port_id_t'($urandom_range(4, 1));
        case (kind)
            0:       leaf = leaf_pkg::leaf_addr_t'(`LEAF_OWN_ADDR + $urandom_range(31, 1));
            1:       port = 4'd0;
            2:       port = 4'd7;
            default: ; // kind 3 clears the valid bit.
        endcase
        send_packet(make_packet(kind != 3, leaf, port, $urandom));
    endtask

    task automatic shuffle_ports();
        int j;
        int t;
        for (int i = 0; i < 4; i++) begin
            port_order[i] = i + 1;
        end
        for (int i = 3; i > 0; i--) begin
            j = $urandom_range(i, 0);
            t = port_order[i];
            port_order[i] = port_order[j];
            port_order[j] = t;
        end
    endtask

    task automatic send_set(input logic with_junk);
        shuffle_ports();
        for (int k = 0; k < 4; k++) begin
            if (with_junk) begin
                send_junk($urandom_range(3, 0));
            end
            send_word(port_order[k], $urandom);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < 200)) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout in %s: %0d result packets did not come out within 200 cycles",
                     test_name, exp_q.size());
        end
        wait_cycles(2);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
        rcv_mark  = received;
        set_mark  = sets_made;
    endtask

    task automatic end_test();
        int want;
        int got;
        want = sets_made - set_mark;
        got  = received - rcv_mark;
        tests++;
        if ((want == got) && (errors == err_mark)) begin
            $display("PASS %s: expected %0d packets, actual %0d", test_name, want, got);
        end else begin
            if (want != got) begin
                errors++;
            end
            $display("FAIL %s: expected %0d packets, actual %0d", test_name, want, got);
        end
    endtask

    // dout is stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && (dout_leaf_interface2bft != '0)) begin
            received++;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
    end

    dout_matches_model: assert property (
        @(negedge clk) disable iff (!rst_n)
        (dout_leaf_interface2bft != '0) |-> (exp_valid && (dout_leaf_interface2bft == exp_head))
    ) else begin
        errors++;
        $display("FAIL %s: expected %h actual %h", test_name, $sampled(exp_head),
                 $sampled(dout_leaf_interface2bft));
    end

    quiet_before_start: assert property (
        @(negedge clk) disable iff (!rst_n) !started |-> (dout_leaf_interface2bft == '0)
    ) else begin
        errors++;
        $display("FAIL %s: expected 0 actual %h", test_name, $sampled(dout_leaf_interface2bft));
    end

    quiet_during_resend: assert property (
        @(negedge clk) disable iff (!rst_n) resend |=> (dout_leaf_interface2bft == '0)
    ) else begin
        errors++;
        $display("FAIL %s: expected 0 actual %h", test_name, $sampled(dout_leaf_interface2bft));
    end

    quiet_after_resend: assert property (
        @(negedge clk) disable iff (!rst_n) $fell(resend) |-> (dout_leaf_interface2bft == '0)
    ) else begin
        errors++;
        $display("FAIL %s: expected 0 actual %h", test_name, $sampled(dout_leaf_interface2bft));
    end

    initial begin
        void'($urandom(32'hd410));
        rst_n                  = 1'b0;
        din_leaf_bft2interface = '0;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        started                = 1'b0;
        exp_tag                = '0;
        exp_head               = '0;
        exp_valid              = 1'b0;
        test_name              = "reset";
        errors                 = 0;
        tests                  = 0;
        received               = 0;
        sets_made              = 0;
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        wait_cycles(2);

        begin_test("no_output_before_start");
        for (int p = 1; p <= 4; p++) begin
            send_word(p, $urandom);
        end
        wait_cycles(20);
        ap_start = 1'b1;
        started  = 1'b1;
        wait_cycles(1);
        ap_start = 1'b0;
        drain_outputs();
        end_test();

        begin_test("sums");
        for (int s = 0; s < 20; s++) begin
            send_set(1'b0);
        end
        drain_outputs();
        end_test();

        begin_test("filtering");
        for (int s = 0; s < 10; s++) begin
            send_set(1'b1);
        end
        drain_outputs();
        end_test();

        begin_test("resend");
        resend = 1'b1;
        for (int s = 0; s < 4; s++) begin
            send_set(1'b0);
        end
        wait_cycles(10);
        resend = 1'b0;
        drain_outputs();
        end_test();

        begin_test("fifo_order_under_backpressure");
        resend = 1'b1;
        for (int k = 0; k < 3; k++) begin
            send_word(2, $urandom);
            send_word(3, $urandom);
        end
        for (int k = 0; k < `LEAF_FIFO_DEPTH; k++) begin
            send_word(1, $urandom); // port 1 fills up.
        end
        wait_cycles(5);
        resend = 1'b0;
        for (int k = 0; k < `LEAF_FIFO_DEPTH; k++) begin
            send_word(4, $urandom);
            if (k >= 3) begin
                send_word(2, $urandom);
                send_word(3, $urandom);
            end
        end
        drain_outputs();
        end_test();

        $display("tests %0d, packets checked %0d, errors %0d", tests, received, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/leaf_pkg.sv
hdl/port_fifo.sv
hdl/leaf_rx_demux.sv
hdl/user_kernel.sv
hdl/leaf_tx_packer.sv
hdl/leaf_i4o1.sv
testbench/tb_leaf_i4o1.sv

//--- Bender.yml
package:
  name: leaf_i4o1

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/leaf_pkg.sv
      - hdl/port_fifo.sv
      - hdl/leaf_rx_demux.sv
      - hdl/user_kernel.sv
      - hdl/leaf_tx_packer.sv
      - hdl/leaf_i4o1.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_leaf_i4o1.sv
